// File: vec_pkg.sv
// Vector unit package
// Register and scalar widths, operation encodings and the structs
// passed between the issue queue, sequencer, register bank and ALU
package vec_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int VLEN      = 64;
    localparam int VLENB     = VLEN / 8;
    localparam int NUM_VREGS = 32;

    typedef logic [VLEN-1:0]  vreg_t;
    typedef logic [VLENB-1:0] vbyte_en_t;
    typedef logic [4:0]       vreg_addr_t;
    typedef logic [31:0]      xlen_t;
    // 0 up to VLEN elements at SEW8
    typedef logic [6:0]       vl_t;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    // Value doubles as a right shift of VLENB
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } vsew_e;

    // Value doubles as a left shift of the group size
    typedef enum logic [1:0] {
        LMUL1 = 2'd0,
        LMUL2 = 2'd1,
        LMUL4 = 2'd2,
        LMUL8 = 2'd3
    } vlmul_e;

    typedef enum logic [2:0] {
        VSETVLI,
        VADD,
        VSUB,
        VAND,
        VOR,
        VXOR,
        VMVXS
    } vec_op_e;

    typedef enum logic [1:0] {
        OPVV,
        OPVX,
        OPVI
    } op_cat_e;

    typedef enum logic {
        V_IDLE,
        V_EXEC
    } vec_state_e;

    //////////////////////////////
    // Structs
    //////////////////////////////

    typedef struct packed {
        vec_op_e    op;
        op_cat_e    cat;
        vreg_addr_t vd;
        vreg_addr_t vs1;
        vreg_addr_t vs2;
        logic       vm;       // 1 = unmasked
        logic [4:0] imm5;
        xlen_t      scalar;   // rs1 value, AVL for vsetvli
        vsew_e      sew;
        vlmul_e     lmul;
    } vec_instr_t;

    typedef struct packed {
        logic       valid;
        vreg_addr_t addr;
        vbyte_en_t  byte_en;
        vreg_t      data;
    } vreg_write_t;

    typedef struct packed {
        logic  valid;
        xlen_t data;
    } scalar_result_t;

endpackage

// File: vec_issue_queue.sv
// Vector instruction issue queue
// Circular FIFO between the issuer and the sequencer. Each pop returns
// one credit to the issuer on the following cycle.
`timescale 1ns/1ps

module vec_issue_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                push_valid_i,
    input  vec_pkg::vec_instr_t push_instr_i,
    input  logic                pop_i,
    output logic                head_valid_o,
    output vec_pkg::vec_instr_t head_o,
    output logic                credit_o
);
    import vec_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    vec_instr_t       mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head_valid_o = (count != '0);
    assign head_o       = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_valid_i) begin
            mem[wr_ptr] <= push_instr_i;
        end
    end

    // Pointers wrap at QUEUE_DEPTH, not at a power of two
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_valid_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push_valid_i && !pop_i) begin
                count <= count + 1'b1;
            end else if (pop_i && !push_valid_i) begin
                count <= count - 1'b1;
            end
            credit_o <= pop_i;
        end
    end

    // Issuer spent a credit it did not hold
    a_no_overflow: assert property (@(posedge clk) disable iff (!reset_n)
        push_valid_i |-> (count < CNT_W'(QUEUE_DEPTH)));

    a_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
        pop_i |-> head_valid_o);

endmodule

// File: vec_csr.sv
// Vector CSRs
// Holds vtype (SEW, LMUL) and vl. Executes vsetvli by clamping the AVL
// to VLMAX and returns the new vl as a registered scalar result.
`timescale 1ns/1ps

module vec_csr (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    we_i,
    input  vec_pkg::xlen_t          avl_i,
    input  vec_pkg::vsew_e          sew_i,
    input  vec_pkg::vlmul_e         lmul_i,
    output vec_pkg::vsew_e          sew_o,
    output vec_pkg::vlmul_e         lmul_o,
    output vec_pkg::vl_t            vl_o,
    output vec_pkg::scalar_result_t scalar_o
);
    import vec_pkg::*;

    vl_t vlmax;
    vl_t vl_next;

    // VLMAX = VLENB / SEW bytes * LMUL
    assign vlmax   = (vl_t'(VLENB) >> sew_i) << lmul_i;
    assign vl_next = (avl_i < xlen_t'(vlmax)) ? vl_t'(avl_i) : vlmax;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sew_o    <= SEW8;
            lmul_o   <= LMUL1;
            vl_o     <= '0;
            scalar_o <= '0;
        end else begin
            if (we_i) begin
                sew_o  <= sew_i;
                lmul_o <= lmul_i;
                vl_o   <= vl_next;
            end
            scalar_o.valid <= we_i;
            scalar_o.data  <= xlen_t'(vl_next);
        end
    end

endmodule

// File: vec_sequencer.sv
// Vector sequencer
// IDLE/EXEC state machine that pops the issue queue, starts vsetvli,
// and steps through a register group one register per cycle. Tracks
// the remaining vl and builds the tail and mask byte enables.
`timescale 1ns/1ps

module vec_sequencer (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 head_valid_i,
    input  vec_pkg::vec_instr_t  head_i,
    output logic                 pop_o,
    output logic                 csr_we_o,
    input  vec_pkg::vsew_e       sew_i,
    input  vec_pkg::vlmul_e      lmul_i,
    input  vec_pkg::vl_t         vl_i,
    input  vec_pkg::vreg_t       v0_i,
    output vec_pkg::vec_instr_t  instr_o,
    output vec_pkg::vreg_addr_t  vs1_addr_o,
    output vec_pkg::vreg_addr_t  vs2_addr_o,
    output vec_pkg::vreg_write_t write_o,
    output logic                 exec_o
);
    import vec_pkg::*;

    vec_state_e  state_q;
    vec_instr_t  instr_q;
    logic [2:0]  cnt_q;
    logic [2:0]  last_q;
    logic [2:0]  group_last;
    vl_t         rem_q;
    vl_t         epr;
    vbyte_en_t   byte_en;
    vreg_write_t write_q;

    //////////////////////////////
    // Issue control
    //////////////////////////////

    // Wait for the previous group to finish its write back
    assign pop_o    = (state_q == V_IDLE) && head_valid_i && !write_q.valid;
    assign csr_we_o = pop_o && (head_i.op == VSETVLI);

    // vmv.x.s touches one register whatever LMUL is
    assign group_last = (head_i.op == VMVXS) ? 3'd0 : 3'((4'd1 << lmul_i) - 4'd1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= V_IDLE;
            cnt_q   <= '0;
            last_q  <= '0;
            rem_q   <= '0;
        end else begin
            unique case (state_q)
                V_IDLE: begin
                    if (pop_o && head_i.op != VSETVLI) begin
                        state_q <= V_EXEC;
                        cnt_q   <= '0;
                        last_q  <= group_last;
                        rem_q   <= vl_i;
                    end
                end
                V_EXEC: begin
                    cnt_q <= cnt_q + 1'b1;
                    rem_q <= (rem_q > epr) ? rem_q - epr : '0;
                    if (cnt_q == last_q) begin
                        state_q <= V_IDLE;
                    end
                end
                default: state_q <= V_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop_o) begin
            instr_q <= head_i;
        end
    end

    assign exec_o     = (state_q == V_EXEC);
    assign instr_o    = instr_q;
    assign vs1_addr_o = instr_q.vs1 + vreg_addr_t'(cnt_q);
    assign vs2_addr_o = instr_q.vs2 + vreg_addr_t'(cnt_q);

    //////////////////////////////
    // Byte enables
    //////////////////////////////

    assign epr = vl_t'(VLENB) >> sew_i;

    // Element e = k * epr + i is live below vl and when v0 allows it
    always_comb begin
        int elem;
        int idx;
        byte_en = '0;
        for (int b = 0; b < VLENB; b++) begin
            elem       = b >> sew_i;
            idx        = int'(cnt_q) * int'(epr) + elem;
            byte_en[b] = (elem < int'(rem_q)) && (instr_q.vm || v0_i[idx]);
        end
    end

    // Data is filled in from the ALU at the top level
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_q <= '0;
        end else begin
            write_q.valid   <= exec_o && (instr_q.op != VMVXS);
            write_q.addr    <= instr_q.vd + vreg_addr_t'(cnt_q);
            write_q.byte_en <= byte_en;
            write_q.data    <= '0;
        end
    end

    assign write_o = write_q;

    // Group count never runs past the last register
    a_state_legal: assert property (@(posedge clk) disable iff (!reset_n)
        (state_q == V_EXEC) |-> (cnt_q <= last_q));

    // vtype must not move under a group in flight
    a_vtype_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (state_q == V_EXEC) |-> ($stable(sew_i) && $stable(lmul_i) && $stable(vl_i)));

endmodule

// File: vec_regbank.sv
// Vector register bank
// 32 registers with two combinational read ports, one byte-enabled
// write port and a dedicated v0 output for masking
`timescale 1ns/1ps

module vec_regbank (
    input  logic                 clk,
    input  logic                 reset_n,
    input  vec_pkg::vreg_addr_t  vs1_addr_i,
    input  vec_pkg::vreg_addr_t  vs2_addr_i,
    input  vec_pkg::vreg_write_t write_i,
    output vec_pkg::vreg_t       vs1_data_o,
    output vec_pkg::vreg_t       vs2_data_o,
    output vec_pkg::vreg_t       v0_o
);
    import vec_pkg::*;

    vreg_t regs [NUM_VREGS];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int r = 0; r < NUM_VREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (write_i.valid) begin
            for (int b = 0; b < VLENB; b++) begin
                if (write_i.byte_en[b]) begin
                    regs[write_i.addr][8*b +: 8] <= write_i.data[8*b +: 8];
                end
            end
        end
    end

    // Reads see the value before this cycle's write
    assign vs1_data_o = regs[vs1_addr_i];
    assign vs2_data_o = regs[vs2_addr_i];
    assign v0_o       = regs[0];

    a_write_addr_known: assert property (@(posedge clk) disable iff (!reset_n)
        write_i.valid |-> !$isunknown(write_i.addr));

endmodule

// File: vec_alu.sv
// Vector integer ALU
// Selects the second operand (vs1, replicated scalar or replicated
// sign-extended immediate), computes the element operation at SEW
// width with no carry across elements, and registers the result.
// vmv.x.s returns element 0 of vs2 instead.
`timescale 1ns/1ps

module vec_alu (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    exec_i,
    input  vec_pkg::vec_instr_t     instr_i,
    input  vec_pkg::vsew_e          sew_i,
    input  vec_pkg::vreg_t          vs1_data_i,
    input  vec_pkg::vreg_t          vs2_data_i,
    output vec_pkg::vreg_t          result_o,
    output vec_pkg::scalar_result_t scalar_o
);
    import vec_pkg::*;

    vreg_t op_b;
    vreg_t res8;
    vreg_t res16;
    vreg_t res32;
    vreg_t result;
    xlen_t imm_ext;
    xlen_t elem0;

    function automatic vreg_t replicate(xlen_t value, vsew_e sew);
        unique case (sew)
            SEW8:    return {VLENB{value[7:0]}};
            SEW16:   return {(VLENB/2){value[15:0]}};
            default: return {(VLENB/4){value}};
        endcase
    endfunction

    // Upper bits are dropped by the caller, so one width serves all SEWs
    function automatic xlen_t elem_op(vec_op_e op, xlen_t a, xlen_t b);
        unique case (op)
            VSUB:    return a - b;
            VAND:    return a & b;
            VOR:     return a | b;
            VXOR:    return a ^ b;
            default: return a + b;
        endcase
    endfunction

    //////////////////////////////
    // Operands
    //////////////////////////////

    assign imm_ext = {{27{instr_i.imm5[4]}}, instr_i.imm5};

    always_comb begin
        unique case (instr_i.cat)
            OPVX:    op_b = replicate(instr_i.scalar, sew_i);
            OPVI:    op_b = replicate(imm_ext, sew_i);
            default: op_b = vs1_data_i;
        endcase
    end

    //////////////////////////////
    // Element operations
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < VLENB; i++) begin
            res8[8*i +: 8] = 8'(elem_op(instr_i.op, xlen_t'(vs2_data_i[8*i +: 8]),
                                        xlen_t'(op_b[8*i +: 8])));
        end
        for (int i = 0; i < VLENB/2; i++) begin
            res16[16*i +: 16] = 16'(elem_op(instr_i.op, xlen_t'(vs2_data_i[16*i +: 16]),
                                            xlen_t'(op_b[16*i +: 16])));
        end
        for (int i = 0; i < VLENB/4; i++) begin
            res32[32*i +: 32] = elem_op(instr_i.op, vs2_data_i[32*i +: 32], op_b[32*i +: 32]);
        end
    end

    always_comb begin
        unique case (sew_i)
            SEW8: begin
                result = res8;
                elem0  = xlen_t'(vs2_data_i[7:0]);
            end
            SEW16: begin
                result = res16;
                elem0  = xlen_t'(vs2_data_i[15:0]);
            end
            default: begin
                result = res32;
                elem0  = vs2_data_i[31:0];
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (exec_i) begin
            result_o <= result;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            scalar_o <= '0;
        end else begin
            scalar_o.valid <= exec_i && (instr_i.op == VMVXS);
            scalar_o.data  <= elem0;
        end
    end

endmodule

// File: vector_unit.sv
// Vector execution unit top level
// Credit-based issue queue feeding a sequencer that drives the CSRs,
// the register bank and the ALU. Exposes the register write port as
// the commit trace and merges the two scalar result sources.
`timescale 1ns/1ps

module vector_unit #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    instr_valid_i,
    input  vec_pkg::vec_instr_t     instr_i,
    output logic                    credit_o,
    output vec_pkg::vreg_write_t    vreg_commit_o,
    output vec_pkg::scalar_result_t scalar_o
);
    import vec_pkg::*;

    vec_instr_t     head;
    logic           head_valid;
    logic           pop;
    logic           csr_we;
    vsew_e          sew;
    vlmul_e         lmul;
    vl_t            vl;
    vreg_t          v0;
    vec_instr_t     exec_instr;
    logic           exec;
    vreg_addr_t     vs1_addr;
    vreg_addr_t     vs2_addr;
    vreg_t          vs1_data;
    vreg_t          vs2_data;
    vreg_t          alu_result;
    vreg_write_t    seq_write;
    vreg_write_t    commit;
    scalar_result_t csr_scalar;
    scalar_result_t alu_scalar;

    vec_issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk          (clk),
        .reset_n      (reset_n),
        .push_valid_i (instr_valid_i),
        .push_instr_i (instr_i),
        .pop_i        (pop),
        .head_valid_o (head_valid),
        .head_o       (head),
        .credit_o     (credit_o)
    );

    vec_csr u_csr (
        .clk      (clk),
        .reset_n  (reset_n),
        .we_i     (csr_we),
        .avl_i    (head.scalar),
        .sew_i    (head.sew),
        .lmul_i   (head.lmul),
        .sew_o    (sew),
        .lmul_o   (lmul),
        .vl_o     (vl),
        .scalar_o (csr_scalar)
    );

    vec_sequencer u_seq (
        .clk          (clk),
        .reset_n      (reset_n),
        .head_valid_i (head_valid),
        .head_i       (head),
        .pop_o        (pop),
        .csr_we_o     (csr_we),
        .sew_i        (sew),
        .lmul_i       (lmul),
        .vl_i         (vl),
        .v0_i         (v0),
        .instr_o      (exec_instr),
        .vs1_addr_o   (vs1_addr),
        .vs2_addr_o   (vs2_addr),
        .write_o      (seq_write),
        .exec_o       (exec)
    );

    vec_regbank u_regbank (
        .clk        (clk),
        .reset_n    (reset_n),
        .vs1_addr_i (vs1_addr),
        .vs2_addr_i (vs2_addr),
        .write_i    (commit),
        .vs1_data_o (vs1_data),
        .vs2_data_o (vs2_data),
        .v0_o       (v0)
    );

    vec_alu u_alu (
        .clk        (clk),
        .reset_n    (reset_n),
        .exec_i     (exec),
        .instr_i    (exec_instr),
        .sew_i      (sew),
        .vs1_data_i (vs1_data),
        .vs2_data_i (vs2_data),
        .result_o   (alu_result),
        .scalar_o   (alu_scalar)
    );

    // Enables and address from the sequencer, data from the ALU stage
    always_comb begin
        commit      = seq_write;
        commit.data = alu_result;
    end

    assign vreg_commit_o = commit;
    assign scalar_o      = csr_scalar.valid ? csr_scalar : alu_scalar;

    // Pop spacing keeps vsetvli and vmv.x.s results apart
    a_scalar_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(csr_scalar.valid && alu_scalar.valid));

endmodule

// File: vec_checker.sv
// Vector unit checker
// Reference model of the register file, vtype and vl. Queues the
// expected commits and scalar results of each issued instruction
// and compares them in order with the DUT outputs.
`timescale 1ns/1ps

module vec_checker (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    instr_valid_i,
    input  vec_pkg::vec_instr_t     instr_i,
    input  vec_pkg::vreg_write_t    vreg_commit_i,
    input  vec_pkg::scalar_result_t scalar_i,
    output int                      err_count_o,
    output logic                    idle_o
);
    import vec_pkg::*;

    vreg_t       model_rf [NUM_VREGS];
    vsew_e       m_sew;
    vlmul_e      m_lmul;
    vl_t         m_vl;
    vreg_write_t exp_commits [$];
    xlen_t       exp_scalars [$];
    int          errors;

    assign err_count_o = errors;

    function automatic int sew_bytes(vsew_e s);
        case (s)
            SEW8:    return 1;
            SEW16:   return 2;
            default: return 4;
        endcase
    endfunction

    function automatic int group_regs(vlmul_e l);
        case (l)
            LMUL1:   return 1;
            LMUL2:   return 2;
            LMUL4:   return 4;
            default: return 8;
        endcase
    endfunction

    function automatic logic [31:0] elem_ref(vec_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            VADD:    return a + b;
            VSUB:    return a - b;
            VAND:    return a & b;
            VOR:     return a | b;
            default: return a ^ b;
        endcase
    endfunction

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] want);
        errors++;
        $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, want);
    endtask

    //////////////////////////////
    // Model
    //////////////////////////////

    task automatic model_issue(vec_instr_t ins);
        int          bytes;
        int          w;
        int          epr;
        int          e;
        logic [31:0] emask;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] vlmax;
        vreg_addr_t  src1;
        vreg_addr_t  src2;
        vreg_t       v0;
        vreg_write_t wr;
        bytes = sew_bytes(m_sew);
        w     = 8 * bytes;
        epr   = VLENB / bytes;
        emask = (w == 32) ? 32'hffff_ffff : (32'd1 << w) - 32'd1;
        v0    = model_rf[0];
        if (ins.op == VSETVLI) begin
            vlmax  = 32'(VLENB / sew_bytes(ins.sew) * group_regs(ins.lmul));
            m_vl   = (ins.scalar < vlmax) ? vl_t'(ins.scalar) : vl_t'(vlmax);
            m_sew  = ins.sew;
            m_lmul = ins.lmul;
            exp_scalars.push_back(xlen_t'(m_vl));
        end else if (ins.op == VMVXS) begin
            exp_scalars.push_back(model_rf[ins.vs2][31:0] & emask);
        end else begin
            for (int k = 0; k < group_regs(m_lmul); k++) begin
                src1       = ins.vs1 + vreg_addr_t'(k);
                src2       = ins.vs2 + vreg_addr_t'(k);
                wr.valid   = 1'b1;
                wr.addr    = ins.vd + vreg_addr_t'(k);
                wr.byte_en = '0;
                wr.data    = '0;
                for (int i = 0; i < epr; i++) begin
                    e = k * epr + i;
                    a = 32'(model_rf[src2] >> (i * w)) & emask;
                    case (ins.cat)
                        OPVX:    b = ins.scalar & emask;
                        OPVI:    b = {{27{ins.imm5[4]}}, ins.imm5} & emask;
                        default: b = 32'(model_rf[src1] >> (i * w)) & emask;
                    endcase
                    wr.data |= vreg_t'(elem_ref(ins.op, a, b) & emask) << (i * w);
                    // Tail past vl and masked-off elements stay untouched
                    if (e < int'(m_vl) && (ins.vm || v0[6'(e)])) begin
                        for (int j = 0; j < bytes; j++) begin
                            wr.byte_en[3'(i * bytes + j)] = 1'b1;
                        end
                    end
                end
                for (int bb = 0; bb < VLENB; bb++) begin
                    if (wr.byte_en[bb]) begin
                        model_rf[wr.addr][8*bb +: 8] = wr.data[8*bb +: 8];
                    end
                end
                exp_commits.push_back(wr);
            end
        end
    endtask

    //////////////////////////////
    // Compare
    //////////////////////////////

    task automatic check_commit();
        vreg_write_t want;
        vreg_t       dmask;
        if (exp_commits.size() == 0) begin
            errors++;
            $display("Error at %0t: commit to v%0d arrived with none expected",
                     $time, vreg_commit_i.addr);
        end else begin
            want = exp_commits.pop_front();
            for (int b = 0; b < VLENB; b++) begin
                dmask[8*b +: 8] = {8{want.byte_en[b]}};
            end
            if (vreg_commit_i.addr != want.addr) begin
                report_mismatch("vreg_commit_o.addr", 64'(vreg_commit_i.addr), 64'(want.addr));
            end
            if (vreg_commit_i.byte_en != want.byte_en) begin
                report_mismatch("vreg_commit_o.byte_en", 64'(vreg_commit_i.byte_en),
                                64'(want.byte_en));
            end
            if ((vreg_commit_i.data & dmask) != (want.data & dmask)) begin
                report_mismatch("vreg_commit_o.data", vreg_commit_i.data & dmask,
                                want.data & dmask);
            end
        end
    endtask

    task automatic check_scalar();
        xlen_t want;
        if (exp_scalars.size() == 0) begin
            errors++;
            $display("Error at %0t: scalar result %0h arrived with none expected",
                     $time, scalar_i.data);
        end else begin
            want = exp_scalars.pop_front();
            if (scalar_i.data != want) begin
                report_mismatch("scalar_o.data", 64'(scalar_i.data), 64'(want));
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset_n) begin
            for (int r = 0; r < NUM_VREGS; r++) begin
                model_rf[r] = '0;
            end
            m_sew  = SEW8;
            m_lmul = LMUL1;
            m_vl   = '0;
            exp_commits.delete();
            exp_scalars.delete();
        end else begin
            if (vreg_commit_i.valid) begin
                check_commit();
            end
            if (scalar_i.valid) begin
                check_scalar();
            end
            if (instr_valid_i) begin
                model_issue(instr_i);
            end
        end
        idle_o = (exp_commits.size() == 0) && (exp_scalars.size() == 0);
    end

endmodule

// File: tb_vector_unit.sv
// Vector unit testbench
// Issues LFSR-driven instructions under credit flow control and
// lets the checker compare every commit and scalar result
`timescale 1ns/1ps

module tb_vector_unit;
    import vec_pkg::*;

    localparam int QUEUE_DEPTH    = 4;
    localparam int NUM_INSTR      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 12 + 100;

    logic           clk;
    logic           reset_n;
    logic           instr_valid;
    vec_instr_t     instr;
    logic           credit;
    vreg_write_t    commit;
    scalar_result_t scalar;
    int             chk_errors;
    logic           chk_idle;
    logic [31:0]    lfsr_state;
    vlmul_e         issued_lmul;
    int             issued;
    int             credit_pulses;
    int             cycles;
    int             tb_errors;

    vector_unit #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_dut (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .credit_o      (credit),
        .vreg_commit_o (commit),
        .scalar_o      (scalar)
    );

    vec_checker u_chk (
        .clk           (clk),
        .reset_n       (reset_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .vreg_commit_i (commit),
        .scalar_i      (scalar),
        .err_count_o   (chk_errors),
        .idle_o        (chk_idle)
    );

    //////////////////////////////
    // Random source
    //////////////////////////////

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic groups_overlap(vreg_addr_t a, int ga, vreg_addr_t b, int gb);
        for (int i = 0; i < ga; i++) begin
            for (int j = 0; j < gb; j++) begin
                if (a + vreg_addr_t'(i) == b + vreg_addr_t'(j)) begin
                    return 1'b1;
                end
            end
        end
        return 1'b0;
    endfunction

    task automatic make_instr(output vec_instr_t ins);
        logic [31:0] r;
        int          g;
        ins = '0;
        draw_bits(4, r);
        if (r < 3) begin
            ins.op = VSETVLI;
            draw_bits(2, r);
            ins.sew = vsew_e'(2'(r % 3));
            draw_bits(2, r);
            ins.lmul = vlmul_e'(r[1:0]);
            // AVL of zero, small values around VLMAX, or a full 32-bit value
            draw_bits(2, r);
            if (r == 3) begin
                draw_bits(32, r);
            end else if (r != 0) begin
                draw_bits(7, r);
            end
            ins.scalar  = r;
            issued_lmul = ins.lmul;
        end else if (r == 3) begin
            ins.op = VMVXS;
            draw_bits(5, r);
            ins.vs2 = vreg_addr_t'(r);
        end else begin
            draw_bits(3, r);
            ins.op = vec_op_e'(3'(r % 5 + 1));
            draw_bits(2, r);
            ins.cat = op_cat_e'(2'(r % 3));
            draw_bits(1, r);
            ins.vm = r[0];
            draw_bits(5, r);
            ins.imm5 = r[4:0];
            draw_bits(32, r);
            ins.scalar = r;
            g = 1 << issued_lmul;
            // Destination group clear of the sources, and of v0 when masked
            do begin
                draw_bits(5, r);
                ins.vd = vreg_addr_t'(r);
                draw_bits(5, r);
                ins.vs1 = vreg_addr_t'(r);
                draw_bits(5, r);
                ins.vs2 = vreg_addr_t'(r);
            end while (groups_overlap(ins.vd, g, ins.vs1, g) ||
                       groups_overlap(ins.vd, g, ins.vs2, g) ||
                       (!ins.vm && groups_overlap(ins.vd, g, 5'd0, 1)));
        end
    endtask

    //////////////////////////////
    // Clock, credits, timeout
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (credit) begin
            credit_pulses <= credit_pulses + 1;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d credits returned",
                     cycles, credit_pulses, NUM_INSTR);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        vec_instr_t  ins;
        logic [31:0] r;
        int          total;
        reset_n       = 1'b0;
        instr_valid   = 1'b0;
        instr         = '0;
        lfsr_state    = 32'h5f86;
        issued_lmul   = LMUL1;
        issued        = 0;
        credit_pulses = 0;
        cycles        = 0;
        tb_errors     = 0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;
        // Send on three cycles in four while a credit is held
        while (issued < NUM_INSTR) begin
            @(posedge clk);
            draw_bits(2, r);
            if (issued - credit_pulses < QUEUE_DEPTH && r[1:0] != 2'b00) begin
                make_instr(ins);
                instr_valid <= 1'b1;
                instr       <= ins;
                issued++;
            end else begin
                instr_valid <= 1'b0;
            end
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        while (credit_pulses != NUM_INSTR || !chk_idle) begin
            @(negedge clk);
        end
        // Quiet window to catch stray outputs
        repeat (16) @(negedge clk);
        if (credit_pulses != NUM_INSTR) begin
            tb_errors++;
            $display("Credit pulses (%0d) differ from instructions issued (%0d)",
                     credit_pulses, NUM_INSTR);
        end
        total = chk_errors + tb_errors;
        $display("Errors: %0d total, %0d from checker, %0d from credits",
                 total, chk_errors, tb_errors);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
vec_pkg.sv
vec_issue_queue.sv
vec_csr.sv
vec_sequencer.sv
vec_regbank.sv
vec_alu.sv
vector_unit.sv
vec_checker.sv
tb_vector_unit.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the vector unit testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_vector_unit \
    -f project.f -o sim_vector_unit
./obj_dir/sim_vector_unit | tee sim.log
if grep -qx "STATUS: PASS" sim.log; then
    exit 0
fi
exit 1
